// ==== compile.f ====
hw/rf_ecc_pkg.sv
hw/rf_ecc_mem.sv
hw/rf_ecc_check.sv
hw/rf_ecc_regfile.sv
sim/tb_rf_ecc.sv

// ==== Makefile ====
# Verilator build and run for the ECC register file

VERILATOR ?= verilator
TOP       ?= tb_rf_ecc
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -j 0
RUN_ARGS  ?=

SRCS := hw/rf_ecc_pkg.sv \
        hw/rf_ecc_mem.sv \
        hw/rf_ecc_check.sv \
        hw/rf_ecc_regfile.sv \
        sim/tb_rf_ecc.sv

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits with a failing status on any error
run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_rf_ecc.sv ====
// ECC register file testbench

`timescale 1ns/1ps

module tb_rf_ecc;

  // Clock period in ns
  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 8;
  localparam int TRAFFIC_CYCLES = 2000;
  localparam int UPSET_ROUNDS   = 30;
  localparam int ISO_CYCLES     = 20;
  // Longest number of cycles any wait on the alert may take
  localparam int WAIT_TIMEOUT   = 1;
  // Stored word of a cleared register with zero data under the inversion mask
  localparam logic [37:0] CLEAN_ZERO_CW = {6'h2A, 32'h0000_0000};

  logic                 clk_i;
  logic                 rst_ni;
  logic                 gpr_we;
  rf_ecc_pkg::rf_addr_t gpr_waddr;
  rf_ecc_pkg::rf_data_t gpr_wdata;
  rf_ecc_pkg::rf_addr_t raddr_a;
  rf_ecc_pkg::rf_addr_t raddr_b;
  rf_ecc_pkg::rf_data_t rdata_a;
  rf_ecc_pkg::rf_data_t rdata_b;
  logic                 alert_major;

  integer seed;

  // Model of the register contents
  // Entry 0 is never written and stays zero
  rf_ecc_pkg::rf_data_t shadow [32];

  rf_ecc_regfile rf_ecc_regfile_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .gpr_we      (gpr_we),
    .gpr_waddr   (gpr_waddr),
    .gpr_wdata   (gpr_wdata),
    .raddr_a     (raddr_a),
    .raddr_b     (raddr_b),
    .rdata_a     (rdata_a),
    .rdata_b     (rdata_b),
    .alert_major (alert_major)
  );

  always begin
    #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  // Picks a stored register in the range 1 to 31
  function automatic rf_ecc_pkg::rf_addr_t random_reg();
    logic [31:0] r;
    r = next_random();
    return rf_ecc_pkg::rf_addr_t'(1 + (r % 31));
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "Value check failed");
    end
  endtask

  // Advances to the next falling edge and applies the write the DUT just took
  task automatic next_cycle();
    @(negedge clk_i);
    if (rst_ni && gpr_we && (gpr_waddr != '0)) begin
      shadow[gpr_waddr] = gpr_wdata;
    end
  endtask

  task automatic drive(input logic we, input rf_ecc_pkg::rf_addr_t wa,
                       input rf_ecc_pkg::rf_data_t wd, input rf_ecc_pkg::rf_addr_t ra,
                       input rf_ecc_pkg::rf_addr_t rb);
    gpr_we    = we;
    gpr_waddr = wa;
    gpr_wdata = wd;
    raddr_a   = ra;
    raddr_b   = rb;
  endtask

  // Read data settles within the low phase, well before the next rising edge
  task automatic check_reads(input string name);
    #1;
    check_eq({name, " port a"}, 64'(shadow[raddr_a]), 64'(rdata_a));
    check_eq({name, " port b"}, 64'(shadow[raddr_b]), 64'(rdata_b));
  endtask

  task automatic wait_alert(input string name, input logic level, input int max_cycles);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && (n < max_cycles)) begin
      next_cycle();
      n++;
      seen = (alert_major === level);
    end
    if (!seen) begin
      $display("Timeout in %s: alert_major did not reach %0b within %0d cycles",
               name, level, max_cycles);
      $display(">>> FAIL");
      $fatal(1, "Alert wait timed out");
    end
  endtask

  // Fault deposits go straight into the storage array, on a falling edge
  task automatic flip_entry(input rf_ecc_pkg::rf_addr_t idx, input rf_ecc_pkg::rf_cw_t mask);
    rf_ecc_pkg::rf_cw_t cw;
    cw = rf_ecc_regfile_inst.u_mem.mem_q[idx];
    rf_ecc_regfile_inst.u_mem.mem_q[idx] = cw ^ mask;
  endtask

  task automatic deposit_entry(input rf_ecc_pkg::rf_addr_t idx, input rf_ecc_pkg::rf_cw_t cw);
    rf_ecc_regfile_inst.u_mem.mem_q[idx] = cw;
  endtask

  // Corrupts one register, reads it on one port and expects the alert next cycle
  // With replace set the word is overwritten, otherwise the mask bits are flipped
  task automatic corrupt_and_recover(input string name, input rf_ecc_pkg::rf_addr_t r,
                                     input rf_ecc_pkg::rf_cw_t mask, input bit replace,
                                     input bit on_b);
    rf_ecc_pkg::rf_data_t bad_data;
    rf_ecc_pkg::rf_data_t fresh;
    rf_ecc_pkg::rf_addr_t ra;
    rf_ecc_pkg::rf_addr_t rb;
    next_cycle();
    check_eq({name, " alert before"}, 64'(1'b0), 64'(alert_major));
    ra = on_b ? '0 : r;
    rb = on_b ? r : '0;
    if (replace) begin
      deposit_entry(r, mask);
      bad_data = mask[31:0];
    end else begin
      flip_entry(r, mask);
      bad_data = shadow[r] ^ mask[31:0];
    end
    drive(1'b0, '0, '0, ra, rb);
    #1;
    // Data leaves uncorrected, so the upset shows on the port
    check_eq({name, " data"}, 64'(bad_data), 64'(on_b ? rdata_b : rdata_a));
    wait_alert({name, " alert"}, 1'b1, WAIT_TIMEOUT);
    fresh = next_random();
    drive(1'b1, r, fresh, ra, rb);
    next_cycle();
    // The rewrite cycle still reads the bad word, so the alert stays high
    check_eq({name, " alert held"}, 64'(1'b1), 64'(alert_major));
    drive(1'b0, '0, '0, ra, rb);
    // Once the new word is read the alert must drop
    wait_alert({name, " clear"}, 1'b0, WAIT_TIMEOUT);
    check_reads({name, " rewrite"});
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < 32; i++) begin
      next_cycle();
      check_eq("reset alert", 64'(1'b0), 64'(alert_major));
      if (i > 0) begin
        check_eq("reset codeword", 64'(CLEAN_ZERO_CW),
                 64'(rf_ecc_regfile_inst.u_mem.mem_q[rf_ecc_pkg::rf_addr_t'(i)]));
      end
      drive(1'b0, '0, '0, rf_ecc_pkg::rf_addr_t'(i), rf_ecc_pkg::rf_addr_t'(31 - i));
      check_reads("reset read");
    end
    next_cycle();
    check_eq("reset alert end", 64'(1'b0), 64'(alert_major));
  endtask

  task automatic run_traffic();
    logic [31:0] pick;
    logic [31:0] addr_bits;
    rf_ecc_pkg::rf_addr_t wa;
    for (int n = 0; n < TRAFFIC_CYCLES; n++) begin
      next_cycle();
      // Alert here belongs to the read of the previous cycle
      check_eq("traffic alert", 64'(1'b0), 64'(alert_major));
      pick = next_random();
      addr_bits = next_random();
      // About one write in five is aimed at x0
      wa = ((pick % 5) == 0) ? '0 : random_reg();
      drive(pick[31], wa, next_random(), addr_bits[4:0], addr_bits[12:8]);
      // Same-cycle write and read of one register must still show the old value
      check_reads("traffic read");
    end
  endtask

  task automatic run_single_upsets();
    int unsigned b;
    for (int n = 0; n < UPSET_ROUNDS; n++) begin
      b = next_random() % 38;
      corrupt_and_recover("single upset", random_reg(), rf_ecc_pkg::rf_cw_t'(1) << b,
                          1'b0, 1'b0);
    end
  endtask

  task automatic run_double_upsets();
    int unsigned b1;
    int unsigned b2;
    rf_ecc_pkg::rf_cw_t mask;
    for (int n = 0; n < UPSET_ROUNDS; n++) begin
      b1 = next_random() % 38;
      // Offset of 1 to 37 keeps the second bit distinct
      b2 = (b1 + 1 + (next_random() % 37)) % 38;
      mask = (rf_ecc_pkg::rf_cw_t'(1) << b1) | (rf_ecc_pkg::rf_cw_t'(1) << b2);
      corrupt_and_recover("double upset", random_reg(), mask, 1'b0, 1'b1);
    end
  endtask

  task automatic check_isolation();
    rf_ecc_pkg::rf_addr_t r;
    rf_ecc_pkg::rf_addr_t oa;
    rf_ecc_pkg::rf_addr_t ob;
    rf_ecc_pkg::rf_data_t fresh;
    r = random_reg();
    next_cycle();
    flip_entry(r, rf_ecc_pkg::rf_cw_t'(1) << (next_random() % 38));
    // Upset register stays unaddressed while others are read
    for (int n = 0; n < ISO_CYCLES; n++) begin
      oa = random_reg();
      ob = random_reg();
      if (oa == r) oa = (r == 5'd31) ? 5'd1 : r + 5'd1;
      if (ob == r) ob = (r == 5'd1) ? 5'd31 : r - 5'd1;
      drive(1'b0, '0, '0, oa, ob);
      check_reads("isolation read");
      next_cycle();
      check_eq("isolation alert", 64'(1'b0), 64'(alert_major));
    end
    drive(1'b0, '0, '0, '0, '0);
    check_reads("x0 read");
    next_cycle();
    check_eq("x0 alert", 64'(1'b0), 64'(alert_major));
    // A write to x0 is dropped and both ports keep reading zero
    drive(1'b1, '0, next_random(), '0, '0);
    check_reads("x0 write same cycle");
    next_cycle();
    drive(1'b0, '0, '0, '0, '0);
    check_reads("x0 write after");
    check_eq("x0 write alert", 64'(1'b0), 64'(alert_major));
    // The upset is still there once the register is addressed
    drive(1'b0, '0, '0, r, '0);
    wait_alert("isolation upset", 1'b1, WAIT_TIMEOUT);
    fresh = next_random();
    drive(1'b1, r, fresh, r, '0);
    next_cycle();
    check_eq("isolation alert held", 64'(1'b1), 64'(alert_major));
    drive(1'b0, '0, '0, r, '0);
    wait_alert("isolation clear", 1'b0, WAIT_TIMEOUT);
    check_reads("isolation rewrite");
  endtask

  initial begin
    seed = 32'h9223_3a12;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    gpr_we = 1'b0;
    gpr_waddr = '0;
    gpr_wdata = '0;
    raddr_a = '0;
    raddr_b = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    check_reset_state();
    run_traffic();
    run_single_upsets();
    run_double_upsets();
    // An all-zero word is read on port A and an all-one word on port B
    corrupt_and_recover("all zero word", random_reg(), '0, 1'b1, 1'b0);
    corrupt_and_recover("all one word", random_reg(), '1, 1'b1, 1'b1);
    check_isolation();

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== hw/rf_ecc_regfile.sv ====
// ECC protected register file

`timescale 1ns/1ps

module rf_ecc_regfile (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Write port from the core
  input  logic                 gpr_we,
  input  rf_ecc_pkg::rf_addr_t gpr_waddr,
  input  rf_ecc_pkg::rf_data_t gpr_wdata,

  // Source operand read ports
  input  rf_ecc_pkg::rf_addr_t raddr_a,
  input  rf_ecc_pkg::rf_addr_t raddr_b,
  output rf_ecc_pkg::rf_data_t rdata_a,
  output rf_ecc_pkg::rf_data_t rdata_b,

  // Major alert on any bad read
  output logic                 alert_major
);

  // Raw codewords between storage and checker
  rf_ecc_pkg::rf_cw_t rcw_a;
  rf_ecc_pkg::rf_cw_t rcw_b;

  // Encodes and stores the words, reads them out combinationally
  rf_ecc_mem u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .gpr_we    (gpr_we),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata),
    .raddr_a   (raddr_a),
    .raddr_b   (raddr_b),
    .rcw_a     (rcw_a),
    .rcw_b     (rcw_b)
  );

  // Checks every read and returns the data bits to the core
  rf_ecc_check u_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .raddr_a     (raddr_a),
    .raddr_b     (raddr_b),
    .rcw_a       (rcw_a),
    .rcw_b       (rcw_b),
    .rdata_a     (rdata_a),
    .rdata_b     (rdata_b),
    .alert_major (alert_major)
  );

endmodule

// ==== hw/rf_ecc_check.sv ====
// Register file read checker

`timescale 1ns/1ps

module rf_ecc_check (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Read addresses, used to mask x0 and to zero its data
  input  rf_ecc_pkg::rf_addr_t raddr_a,
  input  rf_ecc_pkg::rf_addr_t raddr_b,

  // Raw codewords from the storage
  input  rf_ecc_pkg::rf_cw_t   rcw_a,
  input  rf_ecc_pkg::rf_cw_t   rcw_b,

  // Operand data to the core, passed through without correction
  output rf_ecc_pkg::rf_data_t rdata_a,
  output rf_ecc_pkg::rf_data_t rdata_b,

  // Registered alert, one cycle after a bad read
  output logic                 alert_major
);

  // Syndromes of the two read words
  rf_ecc_pkg::rf_ecc_t synd_a;
  rf_ecc_pkg::rf_ecc_t synd_b;

  // Word stuck at all zeros or all ones, which a glitch may produce
  logic stuck_a;
  logic stuck_b;

  // Per-port fault after masking reads of x0
  logic fault_a;
  logic fault_b;

  // Alert flop
  logic alert_q;

  // The code is detect only, a nonzero syndrome is always a fault
  assign synd_a = rf_ecc_pkg::ecc_syndrome(rcw_a);
  assign synd_b = rf_ecc_pkg::ecc_syndrome(rcw_b);

  // Checked separately since these patterns are the most likely upsets
  assign stuck_a = (rcw_a == '0) || (rcw_a == '1);
  assign stuck_b = (rcw_b == '0) || (rcw_b == '1);

  // x0 is not stored and never raises an alert
  assign fault_a = (raddr_a != '0) && ((synd_a != '0) || stuck_a);
  assign fault_b = (raddr_b != '0) && ((synd_b != '0) || stuck_b);

  // Data leaves uncorrected, the alert is the only response to a fault
  assign rdata_a = (raddr_a == '0) ? '0 : rcw_a[rf_ecc_pkg::RF_DATA_W-1:0];
  assign rdata_b = (raddr_b == '0) ? '0 : rcw_b[rf_ecc_pkg::RF_DATA_W-1:0];

  // Not sticky, the alert follows the faults with one cycle of delay
  // It stays high while a bad register is still being addressed
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= fault_a || fault_b;
    end
  end

  assign alert_major = alert_q;

endmodule

// ==== hw/rf_ecc_mem.sv ====
// Register file codeword storage

`timescale 1ns/1ps

module rf_ecc_mem (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Write strobe from the core, sampled on the rising clock edge
  input  logic                gpr_we,
  input  rf_ecc_pkg::rf_addr_t gpr_waddr,
  input  rf_ecc_pkg::rf_data_t gpr_wdata,

  // Read addresses for the two source operands
  input  rf_ecc_pkg::rf_addr_t raddr_a,
  input  rf_ecc_pkg::rf_addr_t raddr_b,

  // Raw codewords as stored, not yet checked
  output rf_ecc_pkg::rf_cw_t   rcw_a,
  output rf_ecc_pkg::rf_cw_t   rcw_b
);

  // Storage for registers 1 to 31
  // Each entry keeps the data and its six check bits together
  rf_ecc_pkg::rf_cw_t mem_q [1:rf_ecc_pkg::RF_NUM_REGS-1];

  // Codeword of the incoming write data
  rf_ecc_pkg::rf_cw_t wcw;

  // Write that actually targets a stored register
  logic we_valid;

  // Full 32-entry read view, with x0 as a constant clean zero
  rf_ecc_pkg::rf_cw_t rd_view [rf_ecc_pkg::RF_NUM_REGS];

  // Check bits are computed once here, before the word is stored
  assign wcw = rf_ecc_pkg::ecc_encode(gpr_wdata);

  // Writes to x0 are dropped, x0 has no storage to change
  assign we_valid = gpr_we && (gpr_waddr != '0);

  // Register zero always reads as the clean code of zero
  // so the checker sees a valid word even if it were not masked
  assign rd_view[0] = rf_ecc_pkg::RF_RESET_CW;

  for (genvar g = 1; g < rf_ecc_pkg::RF_NUM_REGS; g++) begin : g_entry

    // Decode of the write address for this entry
    logic wr_hit;

    assign wr_hit = we_valid && (gpr_waddr == rf_ecc_pkg::rf_addr_t'(g));

    // Reset loads the code of zero rather than an all-zero word
    // A write lands at the edge and is seen by reads the cycle after
    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        mem_q[g] <= rf_ecc_pkg::RF_RESET_CW;
      end else if (wr_hit) begin
        mem_q[g] <= wcw;
      end
    end

    // Stored entries feed the read view unchanged
    assign rd_view[g] = mem_q[g];

  end

  // Read ports are plain muxes on the address
  // A read of the register written in this cycle returns the old word
  assign rcw_a = rd_view[raddr_a];
  assign rcw_b = rd_view[raddr_b];

endmodule

// ==== hw/rf_ecc_pkg.sv ====
// Register file ECC definitions

package rf_ecc_pkg;

  // Widths of the stored word and its parts
  localparam int RF_DATA_W   = 32;
  localparam int RF_ECC_W    = 6;
  localparam int RF_CW_W     = RF_DATA_W + RF_ECC_W;
  localparam int RF_ADDR_W   = 5;
  // Index 0 is hardwired to zero and has no storage
  localparam int RF_NUM_REGS = 32;

  typedef logic [RF_DATA_W-1:0] rf_data_t;
  typedef logic [RF_ECC_W-1:0]  rf_ecc_t;
  // Data sits in the low bits and the check bits on top
  typedef logic [RF_CW_W-1:0]   rf_cw_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // Mask i selects the data bits that feed check bit i
  // Every data column is distinct and of weight three or more
  // Any one or two flipped bits therefore give a nonzero syndrome
  localparam logic [RF_ECC_W-1:0][RF_DATA_W-1:0] ECC_MASKS = {
    32'hDBEF_FC00,
    32'hBBDF_03F0,
    32'h77B8_E38E,
    32'hD774_9A6D,
    32'hAEF2_555B,
    32'h6DF1_2CB7
  };

  // Inverted on encode so that zero data never has zero check bits
  localparam rf_ecc_t ECC_INV = 6'h2A;

  // Codeword of zero data, loaded into every entry in reset
  localparam rf_cw_t RF_RESET_CW = {ECC_INV, {RF_DATA_W{1'b0}}};

  // Builds the stored codeword of a data word
  function automatic rf_cw_t ecc_encode(input rf_data_t data);
    rf_ecc_t ecc;
    for (int i = 0; i < RF_ECC_W; i++) begin
      // Each check bit is the parity of its masked data bits
      ecc[i] = ^(data & ECC_MASKS[i]);
    end
    return {ecc ^ ECC_INV, data};
  endfunction

  // Zero for a clean codeword, nonzero when any check fails
  function automatic rf_ecc_t ecc_syndrome(input rf_cw_t cw);
    rf_cw_t  ref_cw;
    rf_ecc_t stored;
    ref_cw = ecc_encode(cw[RF_DATA_W-1:0]);
    stored = cw[RF_CW_W-1:RF_DATA_W];
    // The inversion mask is in both terms and cancels out here
    return ref_cw[RF_CW_W-1:RF_DATA_W] ^ stored;
  endfunction

endpackage
